//--- testbench/dma_cases.txt
// size_dw  host_addr  dmaie  compl  stall   (hex, one transfer per line)
// compl: 0 none, 1 during the transfer, 2 together with the start
00040 10000000 1 0 0
00050 20001000 0 1 0
00065 30000400 1 0 1
00000 40000000 1 0 0
00024 50002000 1 2 1
00010 60000000 0 0 0
00100 70010000 1 1 1
0002a 80000100 0 2 0
00021 90000000 1 0 1
001ff a0000000 1 1 1
00040 b0000000 1 0 0
0003e c0000800 0 1 1
00060 d0000000 1 2 0
00022 e0000000 1 0 1
00080 f0000000 1 1 0

//--- vlog.f
rtl/dma_pkg.sv
rtl/dma_data_fifo.sv
rtl/dma_tlp_sequencer.sv
rtl/dma_irq_ctrl.sv
rtl/pci_dma_engine.sv
testbench/dma_engine_properties.sv
testbench/tb_pci_dma_engine.sv

//--- Bender.yml
package:
  name: pci_dma_engine

sources:
  - files:
      - rtl/dma_pkg.sv
      - rtl/dma_data_fifo.sv
      - rtl/dma_tlp_sequencer.sv
      - rtl/dma_irq_ctrl.sv
      - rtl/pci_dma_engine.sv
  - target: test
    files:
      - testbench/dma_engine_properties.sv
      - testbench/tb_pci_dma_engine.sv

//--- testbench/tb_pci_dma_engine.sv
/*
 * testbench for the pcie dma write engine
 * file-driven transfer cases checked against a reference model of the tlp split
 */
`default_nettype none

module tb_pci_dma_engine
    import dma_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int MAX_PAYLOAD_DW    = 32;
    localparam int FIFO_DEPTH_LOG2   = 8;
    localparam int PROG_EMPTY_THRESH = 16;
    localparam int N_FIELDS  = 5;       // size, addr, dmaie, compl, stall
    localparam int MAX_CASES = 32;
    localparam int TIMEOUT   = 5000;    // cycles per wait
    localparam int GATE_WAIT = 300;     // quiet cycles for a gated case
    localparam int SEED      = 19;
    localparam int EV_HDR    = 0;       // wait targets
    localparam int EV_DATA   = 1;
    localparam int EV_IRQ    = 2;
    localparam int EV_DONE   = 3;
    localparam int EV_COMPL  = 4;

    logic        pcie_user_clk       = 1'b0;
    logic        pcie_user_rst_n     = 1'b0;
    logic        fifo_wr_en_i        = 1'b0;
    qword_t      fifo_wr_data_i      = '0;
    logic [3:0]  control_i           = '0;
    dma_size_t   dma_size_i          = '0;
    host_addr_t  dma_host_addr_i     = '0;
    logic        req_compl_i         = 1'b0;
    logic        tx_busy_i           = 1'b0;
    logic [5:0]  tx_buf_av_i         = 6'd16;
    logic        cfg_interrupt_rdy_i = 1'b0;
    logic        tlp_req_o;
    tlp_hdr_t    tlp_hdr_o;
    qword_t      dma_data_o;
    logic        dma_data_valid_o;
    logic        req_compl_o;
    logic        cfg_interrupt_o;
    dma_status_t dma_status_o;

    logic [31:0] case_mem [MAX_CASES*N_FIELDS];
    tlp_hdr_t    hdr_q[$];          // headers seen and their cycles
    int          hdr_cyc[$];
    qword_t      data_q[$];
    int          data_cyc[$];
    int          compl_cyc[$];
    qword_t      exp_q[$];          // expected data already byte swapped
    qword_t      word_idx = '0;     // running fill pattern
    int          irq_rises;
    logic        irq_prev  = 1'b0;
    logic        stall_en  = 1'b0;
    logic        timed_out = 1'b0;
    int          cyc, exp_words, xfers, errors, checks, failed_cases;

    pci_dma_engine #(
        .MAX_PAYLOAD_DW   (MAX_PAYLOAD_DW),
        .FIFO_DEPTH_LOG2  (FIFO_DEPTH_LOG2),
        .PROG_EMPTY_THRESH(PROG_EMPTY_THRESH)
    ) i_dut (.*);

    always #50 pcie_user_clk = ~pcie_user_clk;     // 100 ns period

    always @(posedge pcie_user_clk) begin
        cfg_interrupt_rdy_i <= cfg_interrupt_o;     // core answers one cycle later
    end

    // random buffer gaps while stalls are on
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge pcie_user_clk);
            if (stall_en) begin
                tx_buf_av_i <= ($urandom % 2 == 0) ? 6'd0 : 6'd4;
            end else begin
                tx_buf_av_i <= 6'd16;
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // output monitor sampling mid-cycle
    //////////////////////////////////////////////////////////////
    always @(negedge pcie_user_clk) begin
        cyc = cyc + 1;
        if (pcie_user_rst_n) begin
            if (tlp_req_o) begin
                hdr_q.push_back(tlp_hdr_o);
                hdr_cyc.push_back(cyc);
            end
            if (dma_data_valid_o) begin
                data_q.push_back(dma_data_o);
                data_cyc.push_back(cyc);
            end
            if (req_compl_o) begin
                compl_cyc.push_back(cyc);
            end
            if (cfg_interrupt_o && !irq_prev) begin
                irq_rises = irq_rises + 1;
            end
        end
        irq_prev = cfg_interrupt_o;
    end

    // bytes reversed within each dword
    function automatic qword_t swap_dword_bytes(qword_t w);
        qword_t r;
        int     b;
        for (b = 0; b < 8; b++) begin
            r[8*b +: 8] = w[8*((b/4)*4 + 3 - (b%4)) +: 8];
        end
        return r;
    endfunction

    function automatic bit event_seen(int kind);
        case (kind)
            EV_HDR:  return hdr_q.size() > 0;
            EV_DATA: return data_q.size() >= exp_words;
            EV_IRQ:  return (irq_rises > 0) && !cfg_interrupt_o;  // raised and taken
            EV_DONE: return dma_status_o.dma_done;
            default: return compl_cyc.size() > 0;
        endcase
    endfunction

    task automatic wait_for(input int kind, input string what);
        int t;
        t = 0;
        while (!event_seen(kind) && t < TIMEOUT) begin
            @(posedge pcie_user_clk);
            t++;
        end
        if (!event_seen(kind)) begin
            $display("timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        pcie_user_rst_n <= 1'b0;
        control_i       <= '0;
        repeat (10) @(posedge pcie_user_clk);
        pcie_user_rst_n <= 1'b1;
        xfers = 0;      // buffer counter restarts
        @(posedge pcie_user_clk);
    endtask

    task automatic preload_fifo(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            fifo_wr_en_i   <= 1'b1;
            fifo_wr_data_i <= word_idx;
            exp_q.push_back(swap_dword_bytes(word_idx));
            word_idx = word_idx + 1;
            @(posedge pcie_user_clk);
        end
        fifo_wr_en_i <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////
    // one transfer case
    //////////////////////////////////////////////////////////////
    task automatic run_case(input int idx);
        dma_size_t  size;
        host_addr_t addr;
        logic       dmaie, stall, gated;
        int         compl_mode, n_full, rem, n_hdr, pld, dcount, err0, k, n_pre;
        size       = dma_size_t'(case_mem[idx*N_FIELDS]);
        addr       = case_mem[idx*N_FIELDS+1];
        dmaie      = case_mem[idx*N_FIELDS+2][0];
        compl_mode = int'(case_mem[idx*N_FIELDS+3]);   // 1 mid-transfer, 2 with start
        stall      = case_mem[idx*N_FIELDS+4][0];
        err0       = errors;
        timed_out  = 1'b0;
        hdr_q.delete();
        hdr_cyc.delete();
        data_q.delete();
        data_cyc.delete();
        compl_cyc.delete();
        exp_q.delete();
        irq_rises  = 0;
        // full tlps first, then the even part of what is left
        n_full    = size / MAX_PAYLOAD_DW;
        rem       = (size % MAX_PAYLOAD_DW) / 2 * 2;
        n_hdr     = n_full + ((rem != 0) ? 1 : 0);
        exp_words = size / 2;
        gated     = (size == 0) || (exp_words < PROG_EMPTY_THRESH);
        n_pre     = (size == 0) ? PROG_EMPTY_THRESH : exp_words;  // zero size clears prog_empty

        preload_fifo(n_pre);
        dma_size_i      <= size;
        dma_host_addr_i <= addr;
        stall_en        <= stall;
        @(posedge pcie_user_clk);
        control_i[DMAE_BIT]  <= 1'b1;
        control_i[DMAIE_BIT] <= dmaie;
        req_compl_i          <= (compl_mode == 2);
        @(posedge pcie_user_clk);
        req_compl_i <= 1'b0;

        if (gated) begin
            repeat (GATE_WAIT) @(posedge pcie_user_clk);
            check_value("tlp_req_o count", hdr_q.size(), 0);
            check_value("dma_data_valid_o count", data_q.size(), 0);
            check_value("cfg_interrupt_o pulses", irq_rises, 0);
            check_value("dma_status_o.cur_buffer", dma_status_o.cur_buffer, xfers % 8);
        end else begin
            xfers++;
            if (compl_mode == 1) begin
                wait_for(EV_HDR, "first tlp request");
                req_compl_i <= 1'b1;
                @(posedge pcie_user_clk);
                req_compl_i <= 1'b0;
            end
            wait_for(EV_DATA, "last data word");
            check_value("dma_status_o.dma_done at last data", dma_status_o.dma_done, 0);
            wait_for(EV_DONE, "done flag");
            if (dmaie) wait_for(EV_IRQ, "interrupt");
            if (compl_mode != 0) wait_for(EV_COMPL, "completion strobe");
            repeat (20) @(posedge pcie_user_clk);   // room for stray strobes

            check_value("tlp_req_o count", hdr_q.size(), n_hdr);
            for (k = 0; k < n_hdr && k < hdr_q.size(); k++) begin
                pld = (k < n_full) ? MAX_PAYLOAD_DW : rem;
                check_value("tlp_hdr_o.payload_dw", hdr_q[k].payload_dw, pld);
                check_value("tlp_hdr_o.host_addr", hdr_q[k].host_addr,
                            host_addr_t'(addr + k * 4 * MAX_PAYLOAD_DW));
                dcount = 0;     // words up to the next header
                foreach (data_cyc[j]) begin
                    if (data_cyc[j] > hdr_cyc[k] &&
                        (k == hdr_q.size() - 1 || data_cyc[j] < hdr_cyc[k+1])) begin
                        dcount++;
                    end
                end
                check_value("dma_data_valid_o per tlp", dcount, pld / 2);
            end
            check_value("dma_data_valid_o count", data_q.size(), exp_words);
            foreach (data_q[j]) begin
                if (j < exp_q.size()) check_value("dma_data_o", data_q[j], exp_q[j]);
            end
            check_value("req_compl_o count", compl_cyc.size(), compl_mode != 0);
            if (compl_cyc.size() > 0 && data_cyc.size() > 0 && compl_mode == 1) begin
                check_value("req_compl_o after last data", compl_cyc[0] > data_cyc[$], 1);
            end
            if (compl_cyc.size() > 0 && hdr_cyc.size() > 0 && compl_mode == 2) begin
                check_value("req_compl_o before first tlp", compl_cyc[0] < hdr_cyc[0], 1);
            end
            check_value("cfg_interrupt_o pulses", irq_rises, dmaie);
            check_value("cfg_interrupt_o", cfg_interrupt_o, 0);
            check_value("dma_status_o.rsvd", dma_status_o.rsvd, 0);
            check_value("dma_status_o.dma_done", dma_status_o.dma_done, 1);
            check_value("dma_status_o.cur_buffer", dma_status_o.cur_buffer, xfers % 8);
        end

        control_i <= '0;
        stall_en  <= 1'b0;
        @(posedge pcie_user_clk);
        if (gated || timed_out) apply_reset();     // drops the pending start and fifo words
        if (errors == err0) begin
            $display("case %0d: size %0d dw, %0d tlps, ok", idx, size, gated ? 0 : n_hdr);
        end else begin
            $display("case %0d: size %0d dw, %0d errors", idx, size, errors - err0);
            failed_cases++;
        end
    endtask

    initial begin
        int n_cases;
        $readmemh("testbench/dma_cases.txt", case_mem);
        repeat (10) @(posedge pcie_user_clk);
        pcie_user_rst_n <= 1'b1;
        @(posedge pcie_user_clk);
        n_cases = 0;
        while (n_cases < MAX_CASES && !$isunknown(case_mem[n_cases*N_FIELDS])) begin
            run_case(n_cases);
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("no cases could be read from testbench/dma_cases.txt");
            errors++;
        end
        $display("cases %0d, failing cases %0d, checks %0d, errors %0d",
                 n_cases, failed_cases, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/dma_engine_properties.sv
/*
 * protocol checks on the dma engine ports, bound into the dut
 */
`default_nettype none

module dma_engine_properties (
    input wire logic       pcie_user_clk,
    input wire logic       pcie_user_rst_n,
    input wire logic       tlp_req_i,
    input wire logic       compl_i,
    input wire logic       irq_i,
    input wire logic       irq_rdy_i,
    input wire logic       data_valid_i,
    input wire logic [5:0] buf_av_i
);
    timeunit 1ns;
    timeprecision 1ns;

    // header and completion strobes share the tx engine
    a_no_compl_with_hdr: assert property (
        @(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        !(tlp_req_i && compl_i)
    ) else $error("tlp request and completion strobe in the same cycle");

    // msi held until the core takes it
    a_irq_held: assert property (
        @(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        irq_i && !irq_rdy_i |=> irq_i
    ) else $error("interrupt dropped before ready");

    a_data_needs_buf: assert property (
        @(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        data_valid_i |-> ($past(buf_av_i) != 6'd0)      // read only with buffers free
    ) else $error("data strobe after a cycle without tx buffers");

endmodule

bind pci_dma_engine dma_engine_properties i_props (
    .pcie_user_clk  (pcie_user_clk),
    .pcie_user_rst_n(pcie_user_rst_n),
    .tlp_req_i      (tlp_req_o),
    .compl_i        (req_compl_o),
    .irq_i          (cfg_interrupt_o),
    .irq_rdy_i      (cfg_interrupt_rdy_i),
    .data_valid_i   (dma_data_valid_o),
    .buf_av_i       (tx_buf_av_i)
);

`default_nettype wire

//--- rtl/pci_dma_engine.sv
/*
 * pcie dma write engine top
 * fifo, tlp sequencer and interrupt control, byte-swapped data to the tx engine
 */
`default_nettype none

module pci_dma_engine
    import dma_pkg::*;
#(
    parameter int MAX_PAYLOAD_DW    = 32,
    parameter int FIFO_DEPTH_LOG2   = 8,
    parameter int PROG_EMPTY_THRESH = 16
) (
    input  wire logic       pcie_user_clk,
    input  wire logic       pcie_user_rst_n,
    input  wire logic       fifo_wr_en_i,
    input  wire qword_t     fifo_wr_data_i,
    input  wire logic [3:0] control_i,
    input  wire dma_size_t  dma_size_i,
    input  wire host_addr_t dma_host_addr_i,
    input  wire logic       req_compl_i,
    input  wire logic       tx_busy_i,          // tx engine valid, blocks start
    input  wire logic [5:0] tx_buf_av_i,
    input  wire logic       cfg_interrupt_rdy_i,
    output logic            tlp_req_o,
    output tlp_hdr_t        tlp_hdr_o,
    output qword_t          dma_data_o,
    output logic            dma_data_valid_o,
    output logic            req_compl_o,
    output logic            cfg_interrupt_o,
    output dma_status_t     dma_status_o
);

    logic       fifo_rd_en;
    qword_t     fifo_rd_data;
    logic       fifo_prog_empty;
    logic       xfer_start;
    logic       xfer_done;
    logic       dma_done;
    logic [2:0] cur_buffer;
    logic       data_valid_q;

    dma_data_fifo #(
        .FIFO_DEPTH_LOG2  (FIFO_DEPTH_LOG2),
        .PROG_EMPTY_THRESH(PROG_EMPTY_THRESH)
    ) i_fifo (
        .pcie_user_clk  (pcie_user_clk),
        .pcie_user_rst_n(pcie_user_rst_n),
        .wr_en_i        (fifo_wr_en_i),
        .wr_data_i      (fifo_wr_data_i),
        .rd_en_i        (fifo_rd_en),
        .rd_data_o      (fifo_rd_data),
        .prog_empty_o   (fifo_prog_empty)
    );

    dma_tlp_sequencer #(
        .MAX_PAYLOAD_DW(MAX_PAYLOAD_DW)
    ) i_seq (
        .pcie_user_clk    (pcie_user_clk),
        .pcie_user_rst_n  (pcie_user_rst_n),
        .dmae_i           (control_i[DMAE_BIT]),
        .dma_size_i       (dma_size_i),
        .dma_host_addr_i  (dma_host_addr_i),
        .req_compl_i      (req_compl_i),
        .tx_busy_i        (tx_busy_i),
        .tx_buf_av_i      (tx_buf_av_i),
        .fifo_prog_empty_i(fifo_prog_empty),
        .fifo_rd_en_o     (fifo_rd_en),
        .tlp_req_o        (tlp_req_o),
        .tlp_hdr_o        (tlp_hdr_o),
        .req_compl_o      (req_compl_o),
        .xfer_start_o     (xfer_start),
        .xfer_done_o      (xfer_done),
        .cur_buffer_o     (cur_buffer)
    );

    dma_irq_ctrl i_irq (
        .pcie_user_clk      (pcie_user_clk),
        .pcie_user_rst_n    (pcie_user_rst_n),
        .dmaie_i            (control_i[DMAIE_BIT]),
        .xfer_start_i       (xfer_start),
        .xfer_done_i        (xfer_done),
        .cfg_interrupt_rdy_i(cfg_interrupt_rdy_i),
        .cfg_interrupt_o    (cfg_interrupt_o),
        .dma_done_o         (dma_done)
    );

    // fifo data lands one cycle after the read
    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            data_valid_q <= 1'b0;
        end else begin
            data_valid_q <= fifo_rd_en;
        end
    end

    assign dma_data_valid_o = data_valid_q;

    // byte reversal within each dword, dword order kept
    assign dma_data_o = {fifo_rd_data[39:32], fifo_rd_data[47:40],
                         fifo_rd_data[55:48], fifo_rd_data[63:56],
                         fifo_rd_data[7:0],   fifo_rd_data[15:8],
                         fifo_rd_data[23:16], fifo_rd_data[31:24]};

    assign dma_status_o = '{rsvd: 4'h0, dma_done: dma_done, cur_buffer: cur_buffer};

endmodule

`default_nettype wire

//--- rtl/dma_irq_ctrl.sv
/*
 * end-of-transfer interrupt and done flag
 */
`default_nettype none

module dma_irq_ctrl
    import dma_pkg::*;
(
    input  wire logic pcie_user_clk,
    input  wire logic pcie_user_rst_n,
    input  wire logic dmaie_i,
    input  wire logic xfer_start_i,
    input  wire logic xfer_done_i,
    input  wire logic cfg_interrupt_rdy_i,
    output logic      cfg_interrupt_o,
    output logic      dma_done_o
);

    irq_state_t state;
    logic       irq_q;
    logic       done_q;

    //////////////////////////////////////////////////////////////
    // msi request, held until the core takes it
    //////////////////////////////////////////////////////////////
    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            state <= IRQ_IDLE;
            irq_q <= 1'b0;
        end else begin
            case (state)
                IRQ_IDLE: begin
                    if (xfer_done_i && dmaie_i) begin
                        irq_q <= 1'b1;
                        state <= IRQ_WAIT_RDY;
                    end
                end
                IRQ_WAIT_RDY: begin
                    if (cfg_interrupt_rdy_i) begin
                        irq_q <= 1'b0;   // drops the cycle after rdy
                        state <= IRQ_IDLE;
                    end
                end
                default: state <= IRQ_IDLE;
            endcase
        end
    end

    // done flag, set on every end, cleared on the next start
    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            done_q <= 1'b0;
        end else if (xfer_done_i) begin
            done_q <= 1'b1;
        end else if (xfer_start_i) begin
            done_q <= 1'b0;
        end
    end

    assign cfg_interrupt_o = irq_q;
    assign dma_done_o      = done_q;

endmodule

`default_nettype wire

//--- rtl/dma_tlp_sequencer.sv
/*
 * dma transfer sequencer
 * splits a transfer into memory-write tlps, reads the fifo, serves completions
 */
`default_nettype none

module dma_tlp_sequencer
    import dma_pkg::*;
#(
    parameter int MAX_PAYLOAD_DW = 32
) (
    input  wire logic       pcie_user_clk,
    input  wire logic       pcie_user_rst_n,
    input  wire logic       dmae_i,
    input  wire dma_size_t  dma_size_i,
    input  wire host_addr_t dma_host_addr_i,
    input  wire logic       req_compl_i,
    input  wire logic       tx_busy_i,
    input  wire logic [5:0] tx_buf_av_i,
    input  wire logic       fifo_prog_empty_i,
    output logic            fifo_rd_en_o,
    output logic            tlp_req_o,
    output tlp_hdr_t        tlp_hdr_o,
    output logic            req_compl_o,
    output logic            xfer_start_o,
    output logic            xfer_done_o,
    output logic [2:0]      cur_buffer_o
);

    localparam payload_t   MAX_PLD   = payload_t'(MAX_PAYLOAD_DW);
    localparam host_addr_t ADDR_STEP = host_addr_t'(4 * MAX_PAYLOAD_DW);  // bytes per full tlp

    seq_state_t state;

    logic       dmae_q;         // previous enable, for edge detect
    logic       start_pend;     // edge seen, first tlp not yet out
    logic       compl_flag;     // completion request waiting for idle
    tlp_count_t full_left;      // full tlps not yet issued
    logic       rem_pend;       // remainder tlp still to issue
    logic [7:0] qw_left;        // qwords left in current tlp
    tlp_hdr_t   hdr_q;
    logic       tlp_req_q;
    logic       req_compl_q;
    logic       xfer_start_q;
    logic       xfer_done_q;
    logic [2:0] cur_buf_q;

    //////////////////////////////////////////////////////////////
    // transfer split
    //////////////////////////////////////////////////////////////
    tlp_count_t full_tlps;
    payload_t   rem_raw;
    payload_t   rem_dw;
    logic       buf_ok;
    logic       compl_pend;
    logic       start_ok;
    tlp_count_t cur_full;       // full count seen by the header step
    logic       have_full;
    logic       have_rem;
    payload_t   nxt_pld;

    assign full_tlps  = tlp_count_t'(dma_size_i / MAX_PAYLOAD_DW);
    assign rem_raw    = payload_t'(dma_size_i % MAX_PAYLOAD_DW);
    assign rem_dw     = rem_raw & 9'h1fe;      // odd last dword is not sent
    assign buf_ok     = (tx_buf_av_i != 6'd0);
    assign compl_pend = req_compl_i || compl_flag;
    assign start_ok   = start_pend && !fifo_prog_empty_i && (dma_size_i != '0)
                        && !tx_busy_i && !compl_pend;

    // first header looks at the size, later ones at the running counters
    always_comb begin
        if (state == SEQ_FIRST_TLP) begin
            cur_full = full_tlps;
            have_rem = (rem_dw != '0);
        end else begin
            cur_full = full_left;
            have_rem = rem_pend;
        end
        have_full = (cur_full != '0);
        nxt_pld   = have_full ? MAX_PLD : rem_dw;  // full tlps go first
    end

    // one fifo read per cycle with buffers free
    assign fifo_rd_en_o = (state == SEQ_SEND_QW) && buf_ok;

    //////////////////////////////////////////////////////////////
    // sequencer fsm
    //////////////////////////////////////////////////////////////
    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            state        <= SEQ_IDLE;
            dmae_q       <= 1'b0;
            start_pend   <= 1'b0;
            compl_flag   <= 1'b0;
            full_left    <= '0;
            rem_pend     <= 1'b0;
            qw_left      <= '0;
            tlp_req_q    <= 1'b0;
            req_compl_q  <= 1'b0;
            xfer_start_q <= 1'b0;
            xfer_done_q  <= 1'b0;
            cur_buf_q    <= '0;
        end else begin
            // strobes default low
            tlp_req_q    <= 1'b0;
            req_compl_q  <= 1'b0;
            xfer_start_q <= 1'b0;
            xfer_done_q  <= 1'b0;

            dmae_q <= dmae_i;
            if (dmae_i && !dmae_q) begin
                start_pend <= 1'b1;   // l->h on enable
            end
            if (req_compl_i) begin
                compl_flag <= 1'b1;   // kept until served in idle
            end

            case (state)
                SEQ_IDLE: begin
                    if (compl_pend) begin            // completions first
                        if (buf_ok) begin
                            req_compl_q <= 1'b1;
                            compl_flag  <= 1'b0;
                            state       <= SEQ_COMPL;
                        end
                    end else if (start_ok) begin
                        xfer_start_q <= 1'b1;
                        cur_buf_q    <= cur_buf_q + 3'd1;  // next buffer
                        state        <= SEQ_FIRST_TLP;
                    end
                end

                SEQ_FIRST_TLP,
                SEQ_NEXT_TLP: begin
                    if (!have_full && !have_rem) begin
                        // nothing left, also ends a size below two dwords
                        if (state == SEQ_FIRST_TLP) begin
                            start_pend <= 1'b0;
                        end
                        xfer_done_q <= 1'b1;
                        state       <= SEQ_XFER_END;
                    end else if (buf_ok) begin
                        if (state == SEQ_FIRST_TLP) begin
                            start_pend      <= 1'b0;
                            hdr_q.host_addr <= dma_host_addr_i;
                        end else begin
                            hdr_q.host_addr <= hdr_q.host_addr + ADDR_STEP;
                        end
                        hdr_q.payload_dw <= nxt_pld;
                        qw_left          <= nxt_pld[8:1];    // dword pairs
                        if (have_full) begin
                            full_left <= cur_full - 1'b1;
                            rem_pend  <= have_rem;
                        end else begin
                            full_left <= '0;
                            rem_pend  <= 1'b0;           // remainder goes now
                        end
                        tlp_req_q <= 1'b1;
                        state     <= SEQ_SEND_QW;
                    end
                end

                SEQ_SEND_QW: begin
                    if (buf_ok) begin                    // pause on no buffers
                        qw_left <= qw_left - 8'd1;
                        if (qw_left == 8'd1) begin
                            state <= SEQ_TLP_END;        // last read of this tlp
                        end
                    end
                end

                SEQ_TLP_END:  state <= SEQ_NEXT_TLP;
                SEQ_COMPL:    state <= SEQ_IDLE;
                SEQ_XFER_END: state <= SEQ_IDLE;
                default:      state <= SEQ_IDLE;
            endcase
        end
    end

    assign tlp_req_o    = tlp_req_q;
    assign tlp_hdr_o    = hdr_q;
    assign req_compl_o  = req_compl_q;
    assign xfer_start_o = xfer_start_q;
    assign xfer_done_o  = xfer_done_q;
    assign cur_buffer_o = cur_buf_q;

endmodule

`default_nettype wire

//--- rtl/dma_data_fifo.sv
/*
 * single-clock sample fifo
 * registered read port, programmable-empty flag from the fill count
 */
`default_nettype none

module dma_data_fifo
    import dma_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2   = 8,
    parameter int PROG_EMPTY_THRESH = 16
) (
    input  wire logic   pcie_user_clk,
    input  wire logic   pcie_user_rst_n,
    input  wire logic   wr_en_i,
    input  wire qword_t wr_data_i,
    input  wire logic   rd_en_i,
    output qword_t      rd_data_o,
    output logic        prog_empty_o
);

    localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

    qword_t                     mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   fill_cnt;  // one extra bit, holds DEPTH
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr = wr_en_i && (fill_cnt != DEPTH[FIFO_DEPTH_LOG2:0]);  // drop when full
    assign do_rd = rd_en_i && (fill_cnt != '0);                        // ignore when empty

    //////////////////////////////////////////////////////////////
    // storage and read register
    //////////////////////////////////////////////////////////////
    always_ff @(posedge pcie_user_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (do_rd) begin
            rd_data_o <= mem[rd_ptr];   // data one cycle after the read
        end
    end

    //////////////////////////////////////////////////////////////
    // pointers and fill count
    //////////////////////////////////////////////////////////////
    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // count moves only when exactly one side is active
            case ({do_wr, do_rd})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    assign prog_empty_o = (fill_cnt < PROG_EMPTY_THRESH);  // below threshold, hold off start

endmodule

`default_nettype wire

//--- rtl/dma_pkg.sv
/*
 * dma write engine shared types
 * widths, header and status structs, state encodings
 */
`default_nettype none

package dma_pkg;

    //////////////////////////////////////////////////////////////
    // data and address widths
    //////////////////////////////////////////////////////////////
    typedef logic [63:0] qword_t;       // one fifo / tlp data word
    typedef logic [31:0] host_addr_t;   // host byte address
    typedef logic [20:0] dma_size_t;    // dwords, max 1 MB
    typedef logic [8:0]  payload_t;     // tlp payload in dwords
    typedef logic [15:0] tlp_count_t;   // full tlps still to go

    // header handed to the tx engine with each tlp request
    typedef struct packed {
        payload_t   payload_dw;
        host_addr_t host_addr;
    } tlp_hdr_t;

    // status byte as seen by the host
    typedef struct packed {
        logic [3:0] rsvd;       // always zero
        logic       dma_done;
        logic [2:0] cur_buffer;
    } dma_status_t;

    //////////////////////////////////////////////////////////////
    // state machines
    //////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FIRST_TLP,
        SEQ_NEXT_TLP,
        SEQ_SEND_QW,
        SEQ_TLP_END,
        SEQ_COMPL,
        SEQ_XFER_END
    } seq_state_t;

    typedef enum logic {
        IRQ_IDLE,
        IRQ_WAIT_RDY
    } irq_state_t;

    // bit positions inside the 4-bit control field
    localparam int DMAE_BIT  = 0;   // dma enable, start on rising edge
    localparam int DMAIE_BIT = 1;   // interrupt enable

endpackage

`default_nettype wire
